//--- ip_pkg.sv
`default_nettype none

package ip_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] ipv4_addr_t;
	typedef logic [15:0] udp_port_t;
	typedef logic [15:0] len_t;
	typedef logic [7:0]  ip_proto_t;

	// accepted incoming packet, len is the IP payload length
	typedef struct packed {
		ipv4_addr_t src;
		ipv4_addr_t dst;
		ip_proto_t  proto;
		len_t       len;
	} rx_meta_t;

	typedef struct packed {
		ipv4_addr_t dst;
		ip_proto_t  proto;
		len_t       len;  // payload only, no IP header
	} tx_meta_t;

	typedef struct packed {
		byte_t data;
		logic  last;
	} stream_t;

	localparam ipv4_addr_t LOCAL_IP    = 32'hc0a8_0164; // 192.168.1.100
	localparam ipv4_addr_t REMOTE_IP   = 32'hc0a8_010a; // 192.168.1.10
	localparam udp_port_t  LOCAL_PORT  = 16'd5000;
	localparam udp_port_t  REMOTE_PORT = 16'd6000;

	localparam ip_proto_t PROTO_ICMP = 8'd1;
	localparam ip_proto_t PROTO_UDP  = 8'd17;

	localparam len_t  MAX_PAYLOAD = 16'd64;
	localparam int    BUF_AW      = $clog2(MAX_PAYLOAD); // buffer address bits
	localparam len_t  IP_HDR_LEN  = 16'd20;
	localparam byte_t TTL_DEFAULT = 8'd64;

	// ones' complement sum over the ten header words, checksum word given as zero
	function automatic logic [15:0] hdr_csum(input logic [9:0][15:0] words);
		logic [19:0] sum;
		sum = '0;
		for (int i = 0; i < 10; i++) begin
			sum = sum + {4'h0, words[i]};
		end
		sum = {4'h0, sum[15:0]} + {16'h0, sum[19:16]}; // fold carries back in
		sum = {4'h0, sum[15:0]} + {16'h0, sum[19:16]};
		return ~sum[15:0];
	endfunction

endpackage

`default_nettype wire

//--- ipv4_rx_parse.sv
`timescale 1ns/1ps
`default_nettype none

module ipv4_rx_parse (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire ip_pkg::stream_t  rx,
	input  wire logic             rx_valid,
	output ip_pkg::rx_meta_t      rx_meta,
	output logic                  icmp_start,
	output logic                  udp_start,
	output ip_pkg::stream_t       pay,
	output logic                  pay_valid
);

	typedef enum logic [1:0] {S_HDR, S_PAY, S_DROP} state_t;

	state_t            state;
	logic [4:0]        hcnt;
	logic [159:0]      hdr_sr;
	logic [159:0]      hdr_next;
	ip_pkg::len_t      tot_len;
	ip_pkg::ip_proto_t proto;
	ip_pkg::len_t      pay_left;
	logic              hdr_ok;

	// header byte 0 ends up in the top byte after 20 shifts
	assign hdr_next = {hdr_sr[151:0], rx.data};
	assign tot_len  = hdr_next[143:128];
	assign proto    = hdr_next[87:80];

	assign hdr_ok = (hdr_next[159:156] == 4'd4)
		&& (hdr_next[155:152] == 4'd5)
		&& (ip_pkg::hdr_csum({hdr_next[159:80], 16'h0000, hdr_next[63:0]}) == hdr_next[79:64])
		&& (hdr_next[31:0] == ip_pkg::LOCAL_IP)
		&& (tot_len > ip_pkg::IP_HDR_LEN); // zero payload is useless to both blocks

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= S_HDR;
			hcnt       <= '0;
			icmp_start <= 1'b0;
			udp_start  <= 1'b0;
			pay_valid  <= 1'b0;
		end else begin
			icmp_start <= 1'b0;
			udp_start  <= 1'b0;
			pay_valid  <= 1'b0;
			if (rx_valid) begin
				case (state)
					S_HDR: begin
						hcnt <= hcnt + 5'd1;
						if (rx.last) begin
							hcnt <= '0; // runt frame
						end else if (hcnt == 5'd19) begin
							hcnt <= '0;
							if (hdr_ok && proto == ip_pkg::PROTO_ICMP) begin
								icmp_start <= 1'b1;
								state      <= S_PAY;
							end else if (hdr_ok && proto == ip_pkg::PROTO_UDP) begin
								udp_start <= 1'b1;
								state     <= S_PAY;
							end else begin
								state <= S_DROP;
							end
						end
					end
					S_PAY: begin
						pay_valid <= 1'b1;
						if (rx.last) state <= S_HDR;
						else if (pay_left == 16'd1) state <= S_DROP; // trailing padding
					end
					S_DROP: if (rx.last) state <= S_HDR;
					default: state <= S_HDR;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_valid && state == S_HDR) hdr_sr <= hdr_next;
		if (rx_valid && state == S_HDR && hcnt == 5'd19) begin
			rx_meta <= '{src: hdr_next[63:32], dst: hdr_next[31:0], proto: proto,
				len: tot_len - ip_pkg::IP_HDR_LEN};
			pay_left <= tot_len - ip_pkg::IP_HDR_LEN;
		end
		if (rx_valid && state == S_PAY) begin
			pay_left <= pay_left - 16'd1;
			pay.data <= rx.data;
			pay.last <= rx.last || (pay_left == 16'd1); // end at total length
		end
	end

	a_one_start: assert property (@(posedge clk) disable iff (rst)
		!(icmp_start && udp_start));

endmodule

`default_nettype wire

//--- icmp_echo.sv
`timescale 1ns/1ps
`default_nettype none

module icmp_echo (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire ip_pkg::rx_meta_t rx_meta,
	input  wire logic             icmp_start,
	input  wire ip_pkg::stream_t  pay,
	input  wire logic             pay_valid,
	input  wire logic             grant,
	input  wire logic             ready,
	output logic                  req,
	output ip_pkg::tx_meta_t      req_meta,
	output ip_pkg::stream_t       out,
	output logic                  out_valid
);

	typedef enum logic [1:0] {I_IDLE, I_CAP, I_SEND} state_t;

	state_t             state;
	ip_pkg::byte_t      mem [ip_pkg::MAX_PAYLOAD];
	ip_pkg::ipv4_addr_t peer;
	ip_pkg::len_t       msg_len;
	ip_pkg::len_t       cnt;
	logic               is_echo;
	logic [23:0]        acc;      // unfolded word sum from byte 4 on
	logic [16:0]        fold1;
	logic [15:0]        fold2;
	logic [15:0]        reply_csum;
	logic               start_ok;

	// reply needs id and seq, and must fit the buffer
	assign start_ok = icmp_start && state == I_IDLE
		&& rx_meta.len >= 16'd8 && rx_meta.len <= ip_pkg::MAX_PAYLOAD;

	// type and code of the reply are zero so only bytes 4.. contribute
	assign fold1      = {1'b0, acc[15:0]} + {9'h0, acc[23:16]};
	assign fold2      = fold1[15:0] + {15'h0, fold1[16]};
	assign reply_csum = ~fold2;

	assign req       = (state == I_SEND);
	assign req_meta  = '{dst: peer, proto: ip_pkg::PROTO_ICMP, len: msg_len};
	assign out_valid = req && grant;

	always_comb begin
		case (cnt)
			16'd0, 16'd1: out.data = 8'h00; // echo reply, code 0
			16'd2:        out.data = reply_csum[15:8];
			16'd3:        out.data = reply_csum[7:0];
			default:      out.data = mem[cnt[ip_pkg::BUF_AW-1:0]];
		endcase
		out.last = (cnt == msg_len - 16'd1);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= I_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				I_IDLE: if (start_ok) begin
					cnt   <= '0;
					state <= I_CAP;
				end
				I_CAP: if (pay_valid) begin
					cnt <= cnt + 16'd1;
					if (pay.last) begin
						cnt <= '0;
						// short frames or other types are dropped here
						if (is_echo && cnt + 16'd1 == msg_len) state <= I_SEND;
						else state <= I_IDLE;
					end
				end
				I_SEND: if (out_valid && ready) begin
					cnt <= cnt + 16'd1;
					if (out.last) begin
						cnt   <= '0;
						state <= I_IDLE;
					end
				end
				default: state <= I_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok) begin
			peer    <= rx_meta.src;
			msg_len <= rx_meta.len;
			acc     <= '0;
			is_echo <= 1'b0;
		end
		if (state == I_CAP && pay_valid) begin
			mem[cnt[ip_pkg::BUF_AW-1:0]] <= pay.data;
			if (cnt == 16'd0) is_echo <= (pay.data == 8'd8);
			if (cnt == 16'd1 && pay.data != 8'd0) is_echo <= 1'b0;
			if (cnt >= 16'd4) begin
				acc <= acc + (cnt[0] ? {16'h0, pay.data} : {8'h0, pay.data, 8'h0});
			end
		end
	end

endmodule

`default_nettype wire

//--- udp_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module udp_endpoint (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire ip_pkg::rx_meta_t rx_meta,
	input  wire logic             udp_start,
	input  wire ip_pkg::stream_t  pay,
	input  wire logic             pay_valid,
	input  wire ip_pkg::stream_t  user_tx,
	input  wire logic             user_tx_valid,
	input  wire logic             grant,
	input  wire logic             ready,
	output ip_pkg::stream_t       udp_rx,
	output logic                  udp_rx_valid,
	output logic                  user_tx_ready,
	output logic                  req,
	output ip_pkg::tx_meta_t      req_meta,
	output ip_pkg::stream_t       out,
	output logic                  out_valid
);

	typedef enum logic [1:0] {R_IDLE, R_HDR, R_DATA, R_SKIP} rx_state_t;
	typedef enum logic {T_FILL, T_SEND} tx_state_t;

	rx_state_t         rx_state;
	logic [2:0]        hcnt;
	ip_pkg::udp_port_t dport;

	tx_state_t         tx_state;
	ip_pkg::byte_t     mem [ip_pkg::MAX_PAYLOAD];
	ip_pkg::len_t      cnt;      // write index while filling, read index while sending
	ip_pkg::len_t      plen;
	ip_pkg::len_t      udp_len;
	ip_pkg::len_t      pidx;

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_state     <= R_IDLE;
			hcnt         <= '0;
			udp_rx_valid <= 1'b0;
		end else begin
			udp_rx_valid <= 1'b0;
			if (udp_start) begin
				hcnt     <= '0;
				rx_state <= (rx_meta.len > 16'd8) ? R_HDR : R_IDLE; // header only, nothing to deliver
			end else if (pay_valid) begin
				case (rx_state)
					R_HDR: begin
						hcnt <= hcnt + 3'd1;
						if (pay.last) rx_state <= R_IDLE;
						else if (hcnt == 3'd7)
							rx_state <= (dport == ip_pkg::LOCAL_PORT) ? R_DATA : R_SKIP;
					end
					R_DATA: begin
						udp_rx_valid <= 1'b1;
						if (pay.last) rx_state <= R_IDLE;
					end
					R_SKIP: if (pay.last) rx_state <= R_IDLE;
					default: rx_state <= R_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pay_valid && rx_state == R_HDR && hcnt == 3'd2) dport[15:8] <= pay.data;
		if (pay_valid && rx_state == R_HDR && hcnt == 3'd3) dport[7:0]  <= pay.data;
		if (pay_valid && rx_state == R_DATA) udp_rx <= pay; // parser last marks datagram end
	end

	assign user_tx_ready = (tx_state == T_FILL);
	assign udp_len       = plen + 16'd8;
	assign pidx          = cnt - 16'd8;

	assign req       = (tx_state == T_SEND);
	assign req_meta  = '{dst: ip_pkg::REMOTE_IP, proto: ip_pkg::PROTO_UDP, len: udp_len};
	assign out_valid = req && grant;

	always_comb begin
		case (cnt)
			16'd0:   out.data = ip_pkg::LOCAL_PORT[15:8];
			16'd1:   out.data = ip_pkg::LOCAL_PORT[7:0];
			16'd2:   out.data = ip_pkg::REMOTE_PORT[15:8];
			16'd3:   out.data = ip_pkg::REMOTE_PORT[7:0];
			16'd4:   out.data = udp_len[15:8];
			16'd5:   out.data = udp_len[7:0];
			16'd6,
			16'd7:   out.data = 8'h00; // no UDP checksum
			default: out.data = mem[pidx[ip_pkg::BUF_AW-1:0]];
		endcase
		out.last = (cnt == plen + 16'd7);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_state <= T_FILL;
			cnt      <= '0;
		end else begin
			case (tx_state)
				T_FILL: if (user_tx_valid) begin
					cnt <= cnt + 16'd1;
					if (user_tx.last || cnt == ip_pkg::MAX_PAYLOAD - 16'd1) begin
						cnt      <= '0;
						tx_state <= T_SEND;
					end
				end
				T_SEND: if (out_valid && ready) begin
					cnt <= cnt + 16'd1;
					if (out.last) begin
						cnt      <= '0;
						tx_state <= T_FILL;
					end
				end
				default: tx_state <= T_FILL;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (tx_state == T_FILL && user_tx_valid) begin
			mem[cnt[ip_pkg::BUF_AW-1:0]] <= user_tx.data;
			if (user_tx.last || cnt == ip_pkg::MAX_PAYLOAD - 16'd1) plen <= cnt + 16'd1;
		end
	end

endmodule

`default_nettype wire

//--- ip_tx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ip_tx_arbiter (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             icmp_req,
	input  wire ip_pkg::tx_meta_t icmp_meta,
	input  wire ip_pkg::stream_t  icmp_in,
	input  wire logic             icmp_valid,
	input  wire logic             udp_req,
	input  wire ip_pkg::tx_meta_t udp_meta,
	input  wire ip_pkg::stream_t  udp_in,
	input  wire logic             udp_valid,
	input  wire logic             tx_ready,
	output logic                  icmp_grant,
	output logic                  icmp_ready,
	output logic                  udp_grant,
	output logic                  udp_ready,
	output ip_pkg::stream_t       tx,
	output logic                  tx_valid
);

	typedef enum logic [1:0] {A_IDLE, A_HDR, A_PAY} state_t;

	state_t           state;
	logic [4:0]       hcnt;
	logic [15:0]      ident;
	logic             last_udp;  // who went out last, for round-robin
	logic [159:0]     hdr_sr;

	logic             adv;
	logic             pick_udp;
	logic             any_req;
	ip_pkg::tx_meta_t win_meta;
	ip_pkg::len_t     tot_len;
	logic [9:0][15:0] hdr_words;
	logic [15:0]      hdr_sum;
	logic [159:0]     hdr_full;

	ip_pkg::stream_t  sel_in;
	logic             sel_valid;
	logic             pay_adv;
	logic             sel_take;

	// output register can take a byte when empty or being drained
	assign adv = !tx_valid || tx_ready;

	assign any_req  = icmp_req || udp_req;
	assign pick_udp = udp_req && (!icmp_req || !last_udp);
	assign win_meta = pick_udp ? udp_meta : icmp_meta;
	assign tot_len  = ip_pkg::IP_HDR_LEN + win_meta.len;

	// version 4, IHL 5, no flags, checksum slot zero
	assign hdr_words = {16'h4500, tot_len, ident, 16'h0000,
		ip_pkg::TTL_DEFAULT, win_meta.proto, 16'h0000,
		ip_pkg::LOCAL_IP, win_meta.dst};
	assign hdr_sum  = ip_pkg::hdr_csum(hdr_words);
	assign hdr_full = {hdr_words[9:5], hdr_sum, hdr_words[3:0]};

	assign sel_in    = icmp_grant ? icmp_in : udp_in;
	assign sel_valid = icmp_grant ? icmp_valid : udp_valid;
	assign pay_adv   = (state == A_PAY) && adv;
	assign sel_take  = pay_adv && sel_valid;

	assign icmp_ready = icmp_grant && pay_adv;
	assign udp_ready  = udp_grant && pay_adv;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= A_IDLE;
			hcnt       <= '0;
			ident      <= '0;
			last_udp   <= 1'b0;
			icmp_grant <= 1'b0;
			udp_grant  <= 1'b0;
			tx_valid   <= 1'b0;
		end else begin
			if (adv) tx_valid <= 1'b0; // drained, refilled below if there is a byte
			case (state)
				A_IDLE: if (any_req) begin
					icmp_grant <= !pick_udp;
					udp_grant  <= pick_udp;
					last_udp   <= pick_udp;
					ident      <= ident + 16'd1; // header already built with the old value
					hcnt       <= '0;
					state      <= A_HDR;
				end
				A_HDR: if (adv) begin
					tx_valid <= 1'b1;
					hcnt     <= hcnt + 5'd1;
					if (hcnt == 5'd19) state <= A_PAY;
				end
				A_PAY: if (sel_take) begin
					tx_valid <= 1'b1;
					if (sel_in.last) begin
						icmp_grant <= 1'b0;
						udp_grant  <= 1'b0;
						state      <= A_IDLE;
					end
				end
				default: state <= A_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == A_IDLE && any_req) begin
			hdr_sr <= hdr_full;
		end else if (state == A_HDR && adv) begin
			hdr_sr <= {hdr_sr[151:0], 8'h00};
		end

		if (state == A_HDR && adv) begin
			tx <= '{data: hdr_sr[159:152], last: 1'b0};
		end else if (sel_take) begin
			tx <= sel_in;
		end
	end

	a_tx_hold: assert property (@(posedge clk) disable iff (rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx));

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({icmp_grant, udp_grant}));

endmodule

`default_nettype wire

//--- ip_top.sv
`timescale 1ns/1ps
`default_nettype none

module ip_top (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire ip_pkg::stream_t rx,
	input  wire logic            rx_valid,
	input  wire ip_pkg::stream_t user_tx,
	input  wire logic            user_tx_valid,
	input  wire logic            tx_ready,
	output ip_pkg::stream_t      tx,
	output logic                 tx_valid,
	output ip_pkg::stream_t      udp_rx,
	output logic                 udp_rx_valid,
	output logic                 user_tx_ready
);

	ip_pkg::rx_meta_t rx_meta;
	logic             icmp_start;
	logic             udp_start;
	ip_pkg::stream_t  pay;
	logic             pay_valid;

	// request ports toward the arbiter
	logic             icmp_req, icmp_valid, icmp_grant, icmp_ready;
	ip_pkg::tx_meta_t icmp_meta;
	ip_pkg::stream_t  icmp_out;
	logic             udp_req, udp_valid, udp_grant, udp_ready;
	ip_pkg::tx_meta_t udp_meta;
	ip_pkg::stream_t  udp_out;

	ipv4_rx_parse u_parse (
		.clk        (clk),
		.rst        (rst),
		.rx         (rx),
		.rx_valid   (rx_valid),
		.rx_meta    (rx_meta),
		.icmp_start (icmp_start),
		.udp_start  (udp_start),
		.pay        (pay),
		.pay_valid  (pay_valid)
	);

	icmp_echo u_icmp (
		.clk        (clk),
		.rst        (rst),
		.rx_meta    (rx_meta),
		.icmp_start (icmp_start),
		.pay        (pay),
		.pay_valid  (pay_valid),
		.grant      (icmp_grant),
		.ready      (icmp_ready),
		.req        (icmp_req),
		.req_meta   (icmp_meta),
		.out        (icmp_out),
		.out_valid  (icmp_valid)
	);

	udp_endpoint u_udp (
		.clk           (clk),
		.rst           (rst),
		.rx_meta       (rx_meta),
		.udp_start     (udp_start),
		.pay           (pay),
		.pay_valid     (pay_valid),
		.user_tx       (user_tx),
		.user_tx_valid (user_tx_valid),
		.grant         (udp_grant),
		.ready         (udp_ready),
		.udp_rx        (udp_rx),
		.udp_rx_valid  (udp_rx_valid),
		.user_tx_ready (user_tx_ready),
		.req           (udp_req),
		.req_meta      (udp_meta),
		.out           (udp_out),
		.out_valid     (udp_valid)
	);

	ip_tx_arbiter u_arb (
		.clk        (clk),
		.rst        (rst),
		.icmp_req   (icmp_req),
		.icmp_meta  (icmp_meta),
		.icmp_in    (icmp_out),
		.icmp_valid (icmp_valid),
		.udp_req    (udp_req),
		.udp_meta   (udp_meta),
		.udp_in     (udp_out),
		.udp_valid  (udp_valid),
		.tx_ready   (tx_ready),
		.icmp_grant (icmp_grant),
		.icmp_ready (icmp_ready),
		.udp_grant  (udp_grant),
		.udp_ready  (udp_ready),
		.tx         (tx),
		.tx_valid   (tx_valid)
	);

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// high over the first four rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tb_ip_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ip_top;

	logic               clk;
	logic               rst;
	ip_pkg::stream_t    rx;
	logic               rx_valid;
	ip_pkg::stream_t    user_tx;
	logic               user_tx_valid;
	logic               tx_ready = 1'b1;
	ip_pkg::stream_t    tx;
	logic               tx_valid;
	ip_pkg::stream_t    udp_rx;
	logic               udp_rx_valid;
	logic               user_tx_ready;

	ip_pkg::byte_t      frame_q[$];    // rx frame being built
	ip_pkg::byte_t      pay_q[$];      // IP payload of that frame
	ip_pkg::byte_t      icmp_sent[$];
	ip_pkg::byte_t      user_sent[$];
	ip_pkg::byte_t      fr[$];         // output frame under check
	ip_pkg::stream_t    tx_q[$];
	ip_pkg::stream_t    urx_q[$];
	int                 tx_frames = 0;
	int                 frames_taken = 0;
	logic               was_stall = 1'b0;
	ip_pkg::stream_t    held;
	logic               bp_en = 1'b0;
	logic               have_id = 1'b0;
	logic [15:0]        last_id;
	ip_pkg::ipv4_addr_t peer_ip = 32'h0a00_0005; // ping source

	tb_clkgen u_clkgen (
		.clk (clk),
		.rst (rst)
	);

	ip_top dut (
		.clk           (clk),
		.rst           (rst),
		.rx            (rx),
		.rx_valid      (rx_valid),
		.user_tx       (user_tx),
		.user_tx_valid (user_tx_valid),
		.tx_ready      (tx_ready),
		.tx            (tx),
		.tx_valid      (tx_valid),
		.udp_rx        (udp_rx),
		.udp_rx_valid  (udp_rx_valid),
		.user_tx_ready (user_tx_ready)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input ip_pkg::byte_t got,
		input ip_pkg::byte_t exp);
		if (got !== exp) fail_run($sformatf("ERR %s got 0x%02h expected 0x%02h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input ip_pkg::ipv4_addr_t got,
		input ip_pkg::ipv4_addr_t exp);
		if (got !== exp) fail_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	task automatic check_len(input string name, input ip_pkg::len_t got,
		input ip_pkg::len_t exp);
		if (got !== exp) fail_run($sformatf("ERR %s got 0x%04h expected 0x%04h", name, got, exp));
	endtask

	task automatic check_port(input string name, input ip_pkg::udp_port_t got,
		input ip_pkg::udp_port_t exp);
		if (got !== exp) fail_run($sformatf("ERR %s got 0x%04h expected 0x%04h", name, got, exp));
	endtask

	// checksums and identification
	task automatic check_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) fail_run($sformatf("ERR %s got 0x%04h expected 0x%04h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) fail_run($sformatf("ERR %s got 0x%01h expected 0x%01h", name, got, exp));
	endtask

	// internet checksum over n bytes, the two bytes at skip count as zero
	function automatic logic [15:0] inet_csum(input ip_pkg::byte_t q[$], input int from,
		input int n, input int skip);
		logic [31:0] sum;
		logic [15:0] w;
		sum = '0;
		for (int i = 0; i < n; i += 2) begin
			w[15:8] = q[from + i];
			w[7:0]  = (i + 1 < n) ? q[from + i + 1] : 8'h00; // odd tail padded
			if (i == skip) w = 16'h0000;
			sum = sum + {16'h0, w};
		end
		while (sum[31:16] != 16'h0) sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		return ~sum[15:0];
	endfunction

	// output monitor on the DUT's own edge
	always @(posedge clk) begin
		if (!rst) begin
			if (was_stall) begin
				check_bit("tx_valid", tx_valid, 1'b1);
				check_byte("tx.data", tx.data, held.data);
				check_bit("tx.last", tx.last, held.last);
			end
			if (tx_valid && tx_ready) begin
				tx_q.push_back(tx);
				if (tx.last) tx_frames++;
			end
			if (udp_rx_valid) urx_q.push_back(udp_rx);
			was_stall = tx_valid && !tx_ready;
			held      = tx;
		end
	end

	// random back-pressure when enabled
	always @(posedge clk) begin
		logic [31:0] r;
		r = $urandom;
		if (rst || !bp_en) tx_ready <= 1'b1;
		else tx_ready <= r[0];
	end

	// IPv4 header around pay_q, corrupt breaks the checksum
	task automatic build_ipv4(input ip_pkg::ipv4_addr_t src, input ip_pkg::ipv4_addr_t dst,
		input ip_pkg::ip_proto_t proto, input logic corrupt);
		logic [159:0] h;
		logic [15:0]  cs;
		ip_pkg::len_t tot;
		tot = ip_pkg::IP_HDR_LEN + ip_pkg::len_t'(pay_q.size());
		h = {8'h45, 8'h00, tot, 16'h1234, 16'h0000, 8'd64, proto, 16'h0000, src, dst};
		frame_q.delete();
		for (int i = 19; i >= 0; i--) frame_q.push_back(h[i*8 +: 8]);
		cs = inet_csum(frame_q, 0, 20, 10);
		if (corrupt) cs = cs ^ 16'h0100;
		frame_q[10] = cs[15:8];
		frame_q[11] = cs[7:0];
		foreach (pay_q[i]) frame_q.push_back(pay_q[i]);
	endtask

	// ICMP message with id, seq and n random data bytes
	task automatic make_icmp(input ip_pkg::byte_t icmp_type, input int n);
		logic [31:0] r;
		logic [15:0] cs;
		pay_q.delete();
		for (int i = 0; i < n + 8; i++) begin
			r = $urandom;
			pay_q.push_back(r[7:0]);
		end
		pay_q[0] = icmp_type;
		pay_q[1] = 8'h00;
		cs = inet_csum(pay_q, 0, n + 8, 2);
		pay_q[2] = cs[15:8];
		pay_q[3] = cs[7:0];
		icmp_sent = pay_q;
	endtask

	task automatic make_udp(input ip_pkg::udp_port_t dport, input int n);
		logic [31:0]  r;
		ip_pkg::len_t ulen;
		ulen = ip_pkg::len_t'(n) + 16'd8;
		pay_q.delete();
		for (int i = 0; i < n + 8; i++) begin
			r = $urandom;
			pay_q.push_back(r[7:0]);
		end
		pay_q[0] = ip_pkg::REMOTE_PORT[15:8];
		pay_q[1] = ip_pkg::REMOTE_PORT[7:0];
		pay_q[2] = dport[15:8];
		pay_q[3] = dport[7:0];
		pay_q[4] = ulen[15:8];
		pay_q[5] = ulen[7:0];
		pay_q[6] = 8'h00;
		pay_q[7] = 8'h00; // checksum unused
	endtask

	task automatic send_rx();
		foreach (frame_q[i]) begin
			@(posedge clk);
			rx       <= '{data: frame_q[i], last: (i == frame_q.size() - 1)};
			rx_valid <= 1'b1;
		end
		@(posedge clk);
		rx_valid <= 1'b0;
		rx       <= '0;
	endtask

	task automatic push_user(input int n);
		logic [31:0] r;
		int          t;
		user_sent.delete();
		for (int i = 0; i < n; i++) begin
			r = $urandom;
			user_sent.push_back(r[7:0]);
		end
		t = 0;
		@(negedge clk);
		while (!user_tx_ready) begin
			if (t == 2000) fail_run("timeout waiting for user_tx_ready");
			t++;
			@(negedge clk);
		end
		foreach (user_sent[i]) begin
			@(posedge clk);
			user_tx       <= '{data: user_sent[i], last: (i == n - 1)};
			user_tx_valid <= 1'b1;
		end
		@(posedge clk);
		user_tx_valid <= 1'b0;
	endtask

	// pops the next complete output frame into fr
	task automatic get_frame();
		ip_pkg::stream_t s;
		int              t;
		t = 0;
		while (tx_frames == frames_taken) begin
			if (t == 3000) fail_run("timeout waiting for an output frame");
			t++;
			@(negedge clk);
		end
		frames_taken++;
		fr.delete();
		do begin
			s = tx_q.pop_front();
			fr.push_back(s.data);
		end while (!s.last);
	endtask

	task automatic wait_udp_rx(input int n);
		int t;
		t = 0;
		while (urx_q.size() < n) begin
			if (t == 2000) fail_run("timeout waiting for udp_rx bytes");
			t++;
			@(negedge clk);
		end
	endtask

	task automatic expect_quiet(input int n);
		repeat (n) begin
			@(negedge clk);
			if (tx_q.size() != 0 || urx_q.size() != 0) fail_run("unexpected output on tx or udp_rx");
		end
	endtask

	task automatic check_ip_hdr(input ip_pkg::ipv4_addr_t dst, input ip_pkg::ip_proto_t proto,
		input ip_pkg::len_t plen);
		logic [15:0] id;
		check_len("frame length", ip_pkg::len_t'(fr.size()), ip_pkg::IP_HDR_LEN + plen);
		check_byte("ver_ihl", fr[0], 8'h45);
		check_byte("tos", fr[1], 8'h00);
		check_len("total_len", {fr[2], fr[3]}, ip_pkg::IP_HDR_LEN + plen);
		id = {fr[4], fr[5]};
		if (have_id) check_word("ident", id, last_id + 16'd1); // one step per frame
		have_id = 1'b1;
		last_id = id;
		check_word("flags_frag", {fr[6], fr[7]}, 16'h0000);
		check_byte("ttl", fr[8], ip_pkg::TTL_DEFAULT);
		check_byte("proto", fr[9], proto);
		check_word("hdr_csum", {fr[10], fr[11]}, inet_csum(fr, 0, 20, 10));
		check_addr("src", {fr[12], fr[13], fr[14], fr[15]}, ip_pkg::LOCAL_IP);
		check_addr("dst", {fr[16], fr[17], fr[18], fr[19]}, dst);
	endtask

	task automatic check_echo_reply();
		int n;
		n = icmp_sent.size();
		check_ip_hdr(peer_ip, ip_pkg::PROTO_ICMP, ip_pkg::len_t'(n));
		check_byte("icmp_type", fr[20], 8'h00);
		check_byte("icmp_code", fr[21], 8'h00);
		check_word("icmp_csum", {fr[22], fr[23]}, inet_csum(fr, 20, n, 2));
		for (int i = 4; i < n; i++) check_byte("icmp_data", fr[20 + i], icmp_sent[i]);
	endtask

	task automatic check_udp_frame();
		ip_pkg::len_t ulen;
		ulen = ip_pkg::len_t'(user_sent.size()) + 16'd8;
		check_ip_hdr(ip_pkg::REMOTE_IP, ip_pkg::PROTO_UDP, ulen);
		check_port("udp_src_port", {fr[20], fr[21]}, ip_pkg::LOCAL_PORT);
		check_port("udp_dst_port", {fr[22], fr[23]}, ip_pkg::REMOTE_PORT);
		check_len("udp_len", {fr[24], fr[25]}, ulen);
		check_word("udp_csum", {fr[26], fr[27]}, 16'h0000);
		for (int i = 0; i < user_sent.size(); i++) check_byte("udp_data", fr[28 + i], user_sent[i]);
	endtask

	task automatic reset_outputs();
		int t;
		t = 0;
		@(posedge clk);
		@(negedge clk);
		while (rst) begin
			check_bit("tx_valid", tx_valid, 1'b0);
			check_bit("udp_rx_valid", udp_rx_valid, 1'b0);
			if (t == 20) fail_run("reset was never released");
			t++;
			@(negedge clk);
		end
		repeat (4) begin
			check_bit("tx_valid", tx_valid, 1'b0);
			check_bit("udp_rx_valid", udp_rx_valid, 1'b0);
			@(negedge clk);
		end
	endtask

	task automatic ping_echo();
		make_icmp(8'd8, 16);
		build_ipv4(peer_ip, ip_pkg::LOCAL_IP, ip_pkg::PROTO_ICMP, 1'b0);
		send_rx();
		get_frame();
		check_echo_reply();
		expect_quiet(100); // only one reply
	endtask

	task automatic udp_receive();
		ip_pkg::stream_t s;
		make_udp(ip_pkg::LOCAL_PORT, 10);
		build_ipv4(peer_ip, ip_pkg::LOCAL_IP, ip_pkg::PROTO_UDP, 1'b0);
		send_rx();
		wait_udp_rx(10);
		for (int i = 0; i < 10; i++) begin
			s = urx_q.pop_front();
			check_byte("udp_rx.data", s.data, pay_q[8 + i]);
			check_bit("udp_rx.last", s.last, i == 9);
		end
		expect_quiet(50);
	endtask

	task automatic filter_drops();
		make_udp(ip_pkg::LOCAL_PORT, 6);
		build_ipv4(peer_ip, 32'hc0a8_0165, ip_pkg::PROTO_UDP, 1'b0); // not our address
		send_rx();
		make_udp(ip_pkg::LOCAL_PORT, 6);
		build_ipv4(peer_ip, ip_pkg::LOCAL_IP, ip_pkg::PROTO_UDP, 1'b1);
		send_rx();
		make_udp(ip_pkg::LOCAL_PORT + 16'd1, 6);
		build_ipv4(peer_ip, ip_pkg::LOCAL_IP, ip_pkg::PROTO_UDP, 1'b0);
		send_rx();
		make_icmp(8'd13, 8); // timestamp request
		build_ipv4(peer_ip, ip_pkg::LOCAL_IP, ip_pkg::PROTO_ICMP, 1'b0);
		send_rx();
		expect_quiet(200);
	endtask

	task automatic udp_send();
		push_user(24);
		@(negedge clk);
		check_bit("user_tx_ready", user_tx_ready, 1'b0); // datagram waiting to go out
		get_frame();
		check_udp_frame();
		@(negedge clk);
		check_bit("user_tx_ready", user_tx_ready, 1'b1); // buffer free again
		expect_quiet(50);
	endtask

	task automatic arbitration_backpressure();
		logic seen_icmp;
		logic seen_udp;
		seen_icmp = 1'b0;
		seen_udp  = 1'b0;
		@(negedge clk);
		bp_en = 1'b1;
		make_icmp(8'd8, 13); // odd length message
		build_ipv4(peer_ip, ip_pkg::LOCAL_IP, ip_pkg::PROTO_ICMP, 1'b0);
		fork
			send_rx();
			push_user(20);
		join
		repeat (2) begin
			get_frame();
			if (fr.size() > 9 && fr[9] == ip_pkg::PROTO_ICMP && !seen_icmp) begin
				check_echo_reply();
				seen_icmp = 1'b1;
			end else if (fr.size() > 9 && fr[9] == ip_pkg::PROTO_UDP && !seen_udp) begin
				check_udp_frame();
				seen_udp = 1'b1;
			end else begin
				fail_run("unexpected or repeated frame under back-pressure");
			end
		end
		@(negedge clk);
		bp_en = 1'b0;
		expect_quiet(50);
	endtask

	initial begin
		void'($urandom(32'h9d1d));
		rx            = '0;
		rx_valid      = 1'b0;
		user_tx       = '0;
		user_tx_valid = 1'b0;

		reset_outputs();
		ping_echo();
		udp_receive();
		filter_drops();
		udp_send();
		arbitration_backpressure();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
ip_pkg.sv
ipv4_rx_parse.sv
icmp_echo.sv
udp_endpoint.sv
ip_tx_arbiter.sv
ip_top.sv
tb_clkgen.sv
tb_ip_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_ip_top \
	-f verilog.f -o tb_ip_top &&
./obj_dir/tb_ip_top || { echo "simulation failed"; exit 1; }
